/* kbd_pkg.sv */
package kbd_pkg;

    // Generic byte for scan codes and virtual key codes
    typedef logic [7:0] byte_t;

    // Decoded key action as it leaves the prefix folding stage.
    // The lower 9 bits form the translation ROM address.
    typedef struct packed {
        logic  is_break;
        logic  is_extended;
        byte_t code;
    } ps2_kbd_event_t;

    // Translated key event as stored in the queue and read by the host
    typedef struct packed {
        logic  is_break;
        byte_t vk;
    } kbd_event_t;

    // Scan code set 2 prefix bytes
    localparam byte_t PS2_PREFIX_EXT   = 8'hE0;
    localparam byte_t PS2_PREFIX_BREAK = 8'hF0;

    // Event queue holds 2**KBD_FIFO_ADDR_W entries
    localparam int KBD_FIFO_ADDR_W = 5;

    // Translation ROM indexed by {is_extended, code}
    localparam int KROM_ADDR_W = 9;
    localparam     KROM_FILE   = "krom.mem";

endpackage

/* ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx
    import kbd_pkg::*;
(
    input  logic  clk_i,
    input  logic  arst_n_i,
    input  logic  ps2_clk_async_i,
    input  logic  ps2_data_async_i,
    output byte_t data_o,
    output logic  valid_o
);

    // Synchronizer stages plus one extra clock stage for edge detection
    logic        clk_meta_r;
    logic        clk_sync_r;
    logic        clk_prev_r;
    logic        data_meta_r;
    logic        data_sync_r;

    logic        clk_fall_w;
    logic [9:0]  frame_r;
    logic [10:0] frame_next_w;
    logic [3:0]  bit_cnt_r;
    logic        last_bit_w;
    logic        frame_ok_w;

    // Both lines idle high
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            clk_meta_r  <= 1'b1;
            clk_sync_r  <= 1'b1;
            clk_prev_r  <= 1'b1;
            data_meta_r <= 1'b1;
            data_sync_r <= 1'b1;
        end else begin
            clk_meta_r  <= ps2_clk_async_i;
            clk_sync_r  <= clk_meta_r;
            clk_prev_r  <= clk_sync_r;
            data_meta_r <= ps2_data_async_i;
            data_sync_r <= data_meta_r;
        end
    end

    assign clk_fall_w = clk_prev_r & ~clk_sync_r;

    // LSB first, so bits shift in from the top.
    // After eleven bits frame_next_w holds start [0], data [8:1], parity [9], stop [10]
    assign frame_next_w = {data_sync_r, frame_r};
    assign last_bit_w   = (bit_cnt_r == 4'd10);

    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok_w = ~frame_next_w[0] & frame_next_w[10] & (^frame_next_w[9:1]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bit_cnt_r <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (clk_fall_w) begin
                if (last_bit_w) begin
                    bit_cnt_r <= '0;
                    valid_o   <= frame_ok_w;
                end else begin
                    bit_cnt_r <= bit_cnt_r + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clk_fall_w) begin
            frame_r <= frame_next_w[10:1];
            if (last_bit_w) begin
                data_o <= frame_next_w[8:1];
            end
        end
    end

endmodule

/* ps2_kbd.sv */
`timescale 1ns/1ps

module ps2_kbd
    import kbd_pkg::*;
(
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  byte_t          data_i,
    input  logic           valid_i,
    output ps2_kbd_event_t event_o,
    output logic           valid_o
);

    logic ext_pending_r;
    logic brk_pending_r;
    logic is_ext_w;
    logic is_brk_w;
    logic is_key_w;

    assign is_ext_w = (data_i == PS2_PREFIX_EXT);
    assign is_brk_w = (data_i == PS2_PREFIX_BREAK);

    // A byte that is not a prefix completes the key action
    assign is_key_w = valid_i & ~is_ext_w & ~is_brk_w;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ext_pending_r <= 1'b0;
            brk_pending_r <= 1'b0;
            valid_o       <= 1'b0;
        end else begin
            valid_o <= is_key_w;
            if (valid_i) begin
                if (is_ext_w) begin
                    ext_pending_r <= 1'b1;
                end else if (is_brk_w) begin
                    brk_pending_r <= 1'b1;
                end else begin
                    // Flags apply to this key only
                    ext_pending_r <= 1'b0;
                    brk_pending_r <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (is_key_w) begin
            event_o.is_break    <= brk_pending_r;
            event_o.is_extended <= ext_pending_r;
            event_o.code        <= data_i;
        end
    end

endmodule

/* keycode_rom.sv */
`timescale 1ns/1ps

module keycode_rom
    import kbd_pkg::*;
(
    input  logic                   clk_i,
    input  logic [KROM_ADDR_W-1:0] addr_i,
    output byte_t                  data_o
);

    byte_t rom_r [2**KROM_ADDR_W];

    // File is sparse, so unlisted codes stay at 00
    initial begin
        for (int i = 0; i < 2**KROM_ADDR_W; i++) begin
            rom_r[i] = '0;
        end
        $readmemh(KROM_FILE, rom_r);
    end

    always_ff @(posedge clk_i) begin
        data_o <= rom_r[addr_i];
    end

endmodule

/* kbd_fifo.sv */
`timescale 1ns/1ps

module kbd_fifo
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  kbd_event_t write_data_i,
    input  logic       write_enable_i,
    input  logic       read_enable_i,
    output kbd_event_t read_data_o,
    output logic       read_valid_o,
    output logic       empty_o
);

    kbd_event_t mem_r [2**KBD_FIFO_ADDR_W];

    // Extra MSB tells a full queue from an empty one
    logic [KBD_FIFO_ADDR_W:0] wr_ptr_r;
    logic [KBD_FIFO_ADDR_W:0] rd_ptr_r;
    logic                     full_w;
    logic                     do_write_w;
    logic                     do_read_w;

    assign empty_o = (wr_ptr_r == rd_ptr_r);
    assign full_w  = (wr_ptr_r[KBD_FIFO_ADDR_W] != rd_ptr_r[KBD_FIFO_ADDR_W]) &&
                     (wr_ptr_r[KBD_FIFO_ADDR_W-1:0] == rd_ptr_r[KBD_FIFO_ADDR_W-1:0]);

    // PS/2 cannot be held off, so a write into a full queue is lost
    assign do_write_w = write_enable_i & ~full_w;
    assign do_read_w  = read_enable_i & ~empty_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
        end else begin
            if (do_write_w) begin
                wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (do_read_w) begin
                rd_ptr_r <= rd_ptr_r + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_write_w) begin
            mem_r[wr_ptr_r[KBD_FIFO_ADDR_W-1:0]] <= write_data_i;
        end
    end

    // Head entry always on the output in show-ahead mode
    assign read_data_o  = mem_r[rd_ptr_r[KBD_FIFO_ADDR_W-1:0]];
    assign read_valid_o = ~empty_o;

endmodule

/* kbd_controller.sv */
`timescale 1ns/1ps

module kbd_controller
    import kbd_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       ps2_clk_async_i,
    input  logic       ps2_data_async_i,
    input  logic       read_enable_i,
    output kbd_event_t read_data_o,
    output logic       read_valid_o,
    output logic       interrupt_o
);

    byte_t          rx_data_w;
    logic           rx_valid_w;
    ps2_kbd_event_t key_event_w;
    logic           key_valid_w;
    byte_t          vk_w;
    logic           is_break_r;
    logic           vk_valid_r;
    kbd_event_t     fifo_wdata_w;
    logic           fifo_empty_w;

    ps2_rx ps2_rx_inst (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .ps2_clk_async_i  (ps2_clk_async_i),
        .ps2_data_async_i (ps2_data_async_i),
        .data_o           (rx_data_w),
        .valid_o          (rx_valid_w)
    );

    ps2_kbd ps2_kbd_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .data_i   (rx_data_w),
        .valid_i  (rx_valid_w),
        .event_o  (key_event_w),
        .valid_o  (key_valid_w)
    );

    keycode_rom keycode_rom_inst (
        .clk_i  (clk_i),
        .addr_i ({key_event_w.is_extended, key_event_w.code}),
        .data_o (vk_w)
    );

    // Match the ROM's one-cycle read latency
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vk_valid_r <= 1'b0;
        end else begin
            vk_valid_r <= key_valid_w;
        end
    end

    always_ff @(posedge clk_i) begin
        is_break_r <= key_event_w.is_break;
    end

    assign fifo_wdata_w.is_break = is_break_r;
    assign fifo_wdata_w.vk       = vk_w;

    kbd_fifo kbd_fifo_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .write_data_i   (fifo_wdata_w),
        .write_enable_i (vk_valid_r),
        .read_enable_i  (read_enable_i),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .empty_o        (fifo_empty_w)
    );

    // Level interrupt while anything is queued
    assign interrupt_o = ~fifo_empty_w;

endmodule

/* kbd_controller_assert.sv */
`timescale 1ns/1ps

module kbd_controller_assert
    import kbd_pkg::*;
(
    input logic       clk_i,
    input logic       arst_n_i,
    input logic       read_enable_i,
    input kbd_event_t read_data_o,
    input logic       read_valid_o,
    input logic       interrupt_o
);

    // Interrupt is a level copy of the non-empty state
    irq_follows_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        interrupt_o == read_valid_o)
        else $error("interrupt_o differs from read_valid_o");

    // Head entry holds until the host pops it
    head_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        read_valid_o && !read_enable_i |=> $stable(read_data_o))
        else $error("read_data_o changed while the head was not popped");

    outputs_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown({read_valid_o, interrupt_o}) &&
        (!read_valid_o || !$isunknown(read_data_o)))
        else $error("unknown value on a host side output");

endmodule

bind kbd_controller kbd_controller_assert kbd_controller_assert_inst (.*);

/* tb_kbd_controller.sv */
`timescale 1ns/1ps

module tb_kbd_controller
    import kbd_pkg::*;
();

    localparam int PS2_HALF       = 8;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int NUM_ROWS       = 10;

    typedef struct packed {
        byte_t code;
        logic  ext;
        logic  brk;
        logic  bad;
        byte_t vk;
        logic  has_event;
    } key_row_t;

    // code, extended, break, parity error, expected vk, event expected
    key_row_t key_table [NUM_ROWS] = '{
        '{8'h1C, 1'b0, 1'b0, 1'b0, 8'h41, 1'b1},
        '{8'h5A, 1'b0, 1'b0, 1'b0, 8'h0D, 1'b1},
        '{8'h1C, 1'b0, 1'b1, 1'b0, 8'h41, 1'b1},
        '{8'h75, 1'b1, 1'b0, 1'b0, 8'h26, 1'b1},
        '{8'h75, 1'b1, 1'b1, 1'b0, 8'h26, 1'b1},
        '{8'h32, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},
        '{8'h32, 1'b0, 1'b0, 1'b0, 8'h42, 1'b1},
        '{8'h0E, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1},
        '{8'h6B, 1'b1, 1'b0, 1'b0, 8'h25, 1'b1},
        '{8'h29, 1'b0, 1'b1, 1'b0, 8'h20, 1'b1}
    };

    // Mapped make codes for the overflow run
    byte_t pick_code [4] = '{8'h1C, 8'h5A, 8'h32, 8'h29};
    byte_t pick_vk   [4] = '{8'h41, 8'h0D, 8'h42, 8'h20};

    logic       clk;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       read_enable;
    kbd_event_t read_data;
    logic       read_valid;
    logic       interrupt;
    int         err_count;
    int         timeout_count;
    integer     seed;

    kbd_controller kbd_controller_inst (
        .clk_i            (clk),
        .arst_n_i         (arst_n),
        .ps2_clk_async_i  (ps2_clk),
        .ps2_data_async_i (ps2_data),
        .read_enable_i    (read_enable),
        .read_data_o      (read_data),
        .read_valid_o     (read_valid),
        .interrupt_o      (interrupt)
    );

    always #10 clk = ~clk;

    task automatic check_value(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // Start, eight data bits LSB first, odd parity, stop
    task automatic send_frame(byte_t value, logic bad_parity, int nbits);
        logic [10:0] bits;
        bits = {1'b1, ~(^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_data = bits[i];
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (PS2_HALF) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        repeat (PS2_HALF) @(negedge clk);
    endtask

    task automatic send_key(key_row_t row);
        if (row.ext) begin
            send_frame(PS2_PREFIX_EXT, 1'b0, 11);
        end
        if (row.brk) begin
            send_frame(PS2_PREFIX_BREAK, 1'b0, 11);
        end
        send_frame(row.code, row.bad, 11);
    endtask

    task automatic wait_valid(output bit ok);
        int cycles;
        cycles = 0;
        while (!read_valid && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        ok = read_valid;
        if (!ok) begin
            timeout_count++;
            $display("Timeout at %0t: no key event in the queue after %0d cycles",
                     $time, TIMEOUT_CYCLES);
        end
    endtask

    task automatic read_event(logic exp_brk, byte_t exp_vk);
        bit ok;
        wait_valid(ok);
        if (ok) begin
            check_value("interrupt_o", interrupt, 1'b1);
            check_value("read_data_o.is_break", read_data.is_break, exp_brk);
            check_value("read_data_o.vk", read_data.vk, exp_vk);
            read_enable = 1'b1;
            @(negedge clk);
            read_enable = 1'b0;
        end
    endtask

    task automatic check_empty();
        check_value("read_valid_o", read_valid, 1'b0);
        check_value("interrupt_o", interrupt, 1'b0);
    endtask

    initial begin
        bit    ok;
        int    idx;
        byte_t exp_q [$];
        clk           = 1'b0;
        arst_n        = 1'b0;
        ps2_clk       = 1'b1;
        ps2_data      = 1'b1;
        read_enable   = 1'b0;
        err_count     = 0;
        timeout_count = 0;
        seed          = 84;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (5) @(negedge clk);

        // One key at a time, read back before the next
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_key(key_table[r]);
            if (key_table[r].has_event) begin
                read_event(key_table[r].brk, key_table[r].vk);
            end else begin
                repeat (40) @(negedge clk);
            end
            check_empty();
        end

        // Whole table queued, then drained in order
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_key(key_table[r]);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (key_table[r].has_event) begin
                read_event(key_table[r].brk, key_table[r].vk);
            end
        end
        check_empty();

        // Two events more than the queue holds
        for (int n = 0; n < 34; n++) begin
            idx = $random(seed) & 32'h3;
            send_frame(pick_code[idx], 1'b0, 11);
            exp_q.push_back(pick_vk[idx]);
        end
        for (int n = 0; n < 32; n++) begin
            read_event(1'b0, exp_q[n]);
        end
        check_empty();

        // Reset with one entry queued and a frame half sent
        send_key(key_table[1]);
        wait_valid(ok);
        send_frame(8'h1C, 1'b0, 5);
        arst_n = 1'b0;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        repeat (5) @(negedge clk);
        check_empty();
        send_key(key_table[0]);
        read_event(1'b0, 8'h41);
        check_empty();

        $display("Run finished with %0d mismatches and %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* krom.mem */
// Each line is @address then one byte, address = {extended, scan code}
// The byte is the virtual key code; unlisted addresses read 00
@00D 09
@016 31
@01C 41
@01E 32
@021 43
@023 44
@024 45
@029 20
@032 42
@05A 0D
@066 08
@076 1B
// Extended half, E0 prefixed codes
@111 12
@114 11
@16B 25
@172 28
@174 27
@175 26

/* project.f */
kbd_pkg.sv
ps2_rx.sv
ps2_kbd.sv
keycode_rom.sv
kbd_fifo.sv
kbd_controller.sv
kbd_controller_assert.sv
tb_kbd_controller.sv

/* Makefile */
TOP = tb_kbd_controller

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST RESULT: PASS" sim.log && ! grep -q "TEST RESULT: FAIL" sim.log

clean:
	rm -rf obj_dir sim.log
